// File: soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// wishbone byte address and data widths
`define SOC_ADDR_WIDTH 16
`define SOC_DATA_WIDTH 32

// words per on-chip memory, 4 KiB each
`define SOC_MEM_WORDS 1024

// number of leds and switches
`define SOC_GPIO_WIDTH 16

// cycles the internal reset is held after the external one
`define SOC_RST_STRETCH 16

`endif

// File: soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

    // wishbone byte address
    typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

    // data word and its byte selects
    typedef logic [`SOC_DATA_WIDTH-1:0] data_t;
    typedef logic [`SOC_DATA_WIDTH/8-1:0] strb_t;

    // slave chosen by the two top address bits
    typedef enum logic [1:0] {
        region_mem0 = 2'b00,
        region_mem1 = 2'b01,
        region_gpio = 2'b10,
        region_none = 2'b11
    } region_e;

endpackage

// File: rst_stretch.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module rst_stretch (
    input  logic clk,
    input  logic rst,
    output logic rst_sys
);

    localparam int CNT_W = $clog2(`SOC_RST_STRETCH + 1);

    logic [CNT_W-1:0] cnt;
    logic             hold;

    // reload while the external reset is high, count down after it
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= CNT_W'(`SOC_RST_STRETCH);
            hold <= 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            hold <= 1'b0;
        end
    end

    // rises with rst at once, falls a full stretch later
    assign rst_sys = rst | hold;

endmodule

// File: wb_decoder.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module wb_decoder (
    input  logic            clk,
    input  logic            rst,

    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  soc_pkg::addr_t  wb_adr,
    input  soc_pkg::strb_t  wb_sel,
    input  soc_pkg::data_t  wb_dat_w,
    output soc_pkg::data_t  wb_dat_r,
    output logic            wb_ack,

    output logic            stb_mem0,
    output logic            stb_mem1,
    output logic            stb_gpio,
    input  logic            ack_mem0,
    input  logic            ack_mem1,
    input  logic            ack_gpio,
    input  soc_pkg::data_t  dat_mem0,
    input  soc_pkg::data_t  dat_mem1,
    input  soc_pkg::data_t  dat_gpio
);

    import soc_pkg::*;

    region_e region;
    logic    ack_none;

    assign region = region_e'(wb_adr[`SOC_ADDR_WIDTH-1 -: 2]);

    // strobe goes to the addressed slave only
    assign stb_mem0 = wb_cyc && wb_stb && (region == region_mem0);
    assign stb_mem1 = wb_cyc && wb_stb && (region == region_mem1);
    assign stb_gpio = wb_cyc && wb_stb && (region == region_gpio);

    // unmapped space answers by itself, one cycle after stb
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_none <= 1'b0;
        end else begin
            ack_none <= wb_cyc && wb_stb && (region == region_none) && !ack_none;
        end
    end

    // return path, unmapped reads give zero
    always_comb begin
        case (region)
            region_mem0: begin
                wb_ack   = ack_mem0;
                wb_dat_r = dat_mem0;
            end
            region_mem1: begin
                wb_ack   = ack_mem1;
                wb_dat_r = dat_mem1;
            end
            region_gpio: begin
                wb_ack   = ack_gpio;
                wb_dat_r = dat_gpio;
            end
            default: begin
                wb_ack   = ack_none;
                wb_dat_r = '0;
            end
        endcase
    end

endmodule

// File: wb_to_mem.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module wb_to_mem (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       stb,
    input  logic                       cyc,
    input  logic                       we,
    input  soc_pkg::addr_t             adr,
    input  soc_pkg::strb_t             sel,
    input  soc_pkg::data_t             dat_w,
    output soc_pkg::data_t             dat_r,
    output logic                       ack,

    output logic                       mem_req,
    output logic                       mem_we,
    output logic [`SOC_ADDR_WIDTH-3:0] mem_addr,
    output soc_pkg::strb_t             mem_be,
    output soc_pkg::data_t             mem_wdata,
    input  soc_pkg::data_t             mem_rdata
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        ACK
    } state_e;

    state_e state;
    state_e state_next;
    logic   start;

    logic                       we_q;
    logic [`SOC_ADDR_WIDTH-3:0] addr_q;
    strb_t                      be_q;
    data_t                      wdata_q;

    assign start = (state == IDLE) && cyc && stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // one memory request per bus cycle
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = REQ;
                end
            end
            REQ:     state_next = ACK;
            ACK:     state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // request captured as the cycle is accepted
    always_ff @(posedge clk) begin
        if (start) begin
            we_q    <= we;
            addr_q  <= adr[`SOC_ADDR_WIDTH-1:2];
            be_q    <= sel;
            wdata_q <= dat_w;
        end
    end

    assign mem_req   = (state == REQ);
    assign mem_we    = we_q;
    assign mem_addr  = addr_q;
    assign mem_be    = be_q;
    assign mem_wdata = wdata_q;

    // memory output is registered and lands in the ack cycle
    assign ack   = (state == ACK);
    assign dat_r = mem_rdata;

endmodule

// File: sp_mem.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module sp_mem #(
    parameter int SIZE = `SOC_MEM_WORDS
) (
    input  logic                       clk,

    input  logic                       req,
    input  logic                       we,
    input  logic [`SOC_ADDR_WIDTH-3:0] addr,
    input  soc_pkg::strb_t             be,
    input  soc_pkg::data_t             wdata,
    output soc_pkg::data_t             rdata
);

    import soc_pkg::*;

    localparam int IDX_W = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int NB    = $bits(strb_t);

    data_t            mem [SIZE];
    logic [IDX_W-1:0] idx;

    // word index wraps to the array size
    assign idx = IDX_W'(addr % SIZE);

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int b = 0; b < NB; b++) begin
                    if (be[b]) begin
                        mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
            // read-before-write, old word comes out
            rdata <= mem[idx];
        end
    end

endmodule

// File: gpio_regs.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module gpio_regs (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       stb,
    input  logic                       we,
    input  soc_pkg::addr_t             adr,
    input  soc_pkg::strb_t             sel,
    input  soc_pkg::data_t             dat_w,
    output soc_pkg::data_t             dat_r,
    output logic                       ack,

    input  logic [`SOC_GPIO_WIDTH-1:0] sw,
    output logic [`SOC_GPIO_WIDTH-1:0] led
);

    import soc_pkg::*;

    localparam int W  = `SOC_GPIO_WIDTH;
    localparam int NB = W / 8;

    logic [W-1:0] led_q;
    logic [W-1:0] sw_meta;
    logic [W-1:0] sw_sync;
    logic         ack_q;
    logic         done;
    logic         access;

    // served once per strobe, rearmed when stb drops
    assign access = stb && !ack_q && !done;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            done  <= 1'b0;
        end else begin
            ack_q <= access;
            if (!stb) begin
                done <= 1'b0;
            end else if (ack_q) begin
                done <= 1'b1;
            end
        end
    end

    // led register, 0x0 writes by byte, 0x8 toggles
    always_ff @(posedge clk) begin
        if (rst) begin
            led_q <= '0;
        end else if (access && we) begin
            case (adr[3:2])
                2'd0: begin
                    for (int b = 0; b < NB; b++) begin
                        if (sel[b]) begin
                            led_q[8*b +: 8] <= dat_w[8*b +: 8];
                        end
                    end
                end
                2'd2:    led_q <= led_q ^ dat_w[W-1:0];
                default: led_q <= led_q;
            endcase
        end
    end

    // two-flop synchronizer for the switches
    always_ff @(posedge clk) begin
        sw_meta <= sw;
        sw_sync <= sw_meta;
    end

    always_comb begin
        case (adr[3:2])
            2'd0:    dat_r = data_t'(led_q);
            2'd1:    dat_r = data_t'(sw_sync);
            2'd2:    dat_r = data_t'(led_q);
            default: dat_r = '0;
        endcase
    end

    assign ack = ack_q;
    assign led = led_q;

endmodule

// File: soc_board.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_board (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  soc_pkg::addr_t             wb_adr,
    input  soc_pkg::strb_t             wb_sel,
    input  soc_pkg::data_t             wb_dat_w,
    output soc_pkg::data_t             wb_dat_r,
    output logic                       wb_ack,

    input  logic [`SOC_GPIO_WIDTH-1:0] sw,
    output logic [`SOC_GPIO_WIDTH-1:0] led
);

    import soc_pkg::*;

    logic rst_sys;

    logic  stb_mem0;
    logic  stb_mem1;
    logic  stb_gpio;
    logic  ack_mem0;
    logic  ack_mem1;
    logic  ack_gpio;
    data_t dat_mem0;
    data_t dat_mem1;
    data_t dat_gpio;

    logic                       mem0_req;
    logic                       mem0_we;
    logic [`SOC_ADDR_WIDTH-3:0] mem0_addr;
    strb_t                      mem0_be;
    data_t                      mem0_wdata;
    data_t                      mem0_rdata;

    logic                       mem1_req;
    logic                       mem1_we;
    logic [`SOC_ADDR_WIDTH-3:0] mem1_addr;
    strb_t                      mem1_be;
    data_t                      mem1_wdata;
    data_t                      mem1_rdata;

    rst_stretch i_rst_stretch (
        .clk     (clk),
        .rst     (rst),
        .rst_sys (rst_sys)
    );

    wb_decoder i_wb_decoder (
        .clk      (clk),
        .rst      (rst_sys),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .stb_mem0 (stb_mem0),
        .stb_mem1 (stb_mem1),
        .stb_gpio (stb_gpio),
        .ack_mem0 (ack_mem0),
        .ack_mem1 (ack_mem1),
        .ack_gpio (ack_gpio),
        .dat_mem0 (dat_mem0),
        .dat_mem1 (dat_mem1),
        .dat_gpio (dat_gpio)
    );

    // mem0 at 0x0000
    wb_to_mem i_mem0_bridge (
        .clk       (clk),
        .rst       (rst_sys),
        .stb       (stb_mem0),
        .cyc       (wb_cyc),
        .we        (wb_we),
        .adr       (wb_adr),
        .sel       (wb_sel),
        .dat_w     (wb_dat_w),
        .dat_r     (dat_mem0),
        .ack       (ack_mem0),
        .mem_req   (mem0_req),
        .mem_we    (mem0_we),
        .mem_addr  (mem0_addr),
        .mem_be    (mem0_be),
        .mem_wdata (mem0_wdata),
        .mem_rdata (mem0_rdata)
    );

    sp_mem #(
        .SIZE (`SOC_MEM_WORDS)
    ) i_mem0 (
        .clk   (clk),
        .req   (mem0_req),
        .we    (mem0_we),
        .addr  (mem0_addr),
        .be    (mem0_be),
        .wdata (mem0_wdata),
        .rdata (mem0_rdata)
    );

    // mem1 at 0x4000
    wb_to_mem i_mem1_bridge (
        .clk       (clk),
        .rst       (rst_sys),
        .stb       (stb_mem1),
        .cyc       (wb_cyc),
        .we        (wb_we),
        .adr       (wb_adr),
        .sel       (wb_sel),
        .dat_w     (wb_dat_w),
        .dat_r     (dat_mem1),
        .ack       (ack_mem1),
        .mem_req   (mem1_req),
        .mem_we    (mem1_we),
        .mem_addr  (mem1_addr),
        .mem_be    (mem1_be),
        .mem_wdata (mem1_wdata),
        .mem_rdata (mem1_rdata)
    );

    sp_mem #(
        .SIZE (`SOC_MEM_WORDS)
    ) i_mem1 (
        .clk   (clk),
        .req   (mem1_req),
        .we    (mem1_we),
        .addr  (mem1_addr),
        .be    (mem1_be),
        .wdata (mem1_wdata),
        .rdata (mem1_rdata)
    );

    // leds and switches at 0x8000
    gpio_regs i_gpio (
        .clk   (clk),
        .rst   (rst_sys),
        .stb   (stb_gpio),
        .we    (wb_we),
        .adr   (wb_adr),
        .sel   (wb_sel),
        .dat_w (wb_dat_w),
        .dat_r (dat_gpio),
        .ack   (ack_gpio),
        .sw    (sw),
        .led   (led)
    );

endmodule

// File: tb_soc_board.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_board;

    import soc_pkg::*;

    localparam int GW = `SOC_GPIO_WIDTH;

    logic          clk;
    logic          rst;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    addr_t         wb_adr;
    strb_t         wb_sel;
    data_t         wb_dat_w;
    data_t         wb_dat_r;
    logic          wb_ack;
    logic [GW-1:0] sw;
    logic [GW-1:0] led;

    int            errors;
    int            checks;
    integer        seed;
    logic [7:0]    mem_model [int];
    logic [GW-1:0] led_model;
    addr_t         written [$];

    soc_board i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sw       (sw),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ack is a one-cycle pulse per transfer
    ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $display("error at time %0t: wb_ack expected 0, got 1", $time);
            errors++;
        end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // byte location in the model, each memory wraps at its size
    function automatic int model_key(input addr_t adr, input int b);
        int word;
        word = int'(adr[13:2]) % `SOC_MEM_WORDS;
        return int'(adr[14]) * 4096 + word * 4 + b;
    endfunction

    // one classic cycle, entered and left 1 ns after a rising edge
    task automatic wb_access(input logic we, input addr_t adr, input strb_t sel,
                             input data_t wdata, output data_t rdata, output int lat);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            n++;
        end while (wb_ack !== 1'b1 && n < 50);
        if (wb_ack !== 1'b1) begin
            $display("timeout: no acknowledge within 50 cycles for access to %h", adr);
            errors++;
        end
        rdata = wb_dat_r;
        lat   = n - 1;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // idle cycle between transfers
        @(posedge clk);
        #1;
    endtask

    task automatic mem_write(input addr_t adr, input strb_t sel, input data_t data);
        data_t rd;
        int    lat;
        wb_access(1'b1, adr, sel, data, rd, lat);
        check_value("wb_ack latency", 2, lat);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                mem_model[model_key(adr, b)] = data[8*b +: 8];
            end
        end
    endtask

    // bytes never written are left out of the compare
    task automatic mem_read_check(input addr_t adr);
        data_t rd;
        data_t exp;
        data_t mask;
        int    lat;
        exp  = '0;
        mask = '0;
        wb_access(1'b0, adr, 4'hf, '0, rd, lat);
        check_value("wb_ack latency", 2, lat);
        for (int b = 0; b < 4; b++) begin
            if (mem_model.exists(model_key(adr, b))) begin
                exp[8*b +: 8]  = mem_model[model_key(adr, b)];
                mask[8*b +: 8] = 8'hff;
            end
        end
        check_value("wb_dat_r", exp & mask, rd & mask);
    endtask

    // gpio and unmapped space answer one cycle after stb
    task automatic reg_access(input logic we, input addr_t adr, input strb_t sel,
                              input data_t wdata, output data_t rdata);
        int lat;
        wb_access(we, adr, sel, wdata, rdata, lat);
        check_value("wb_ack latency", 1, lat);
    endtask

    task automatic watch_reset(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_value("wb_ack", 1'b0, wb_ack);
            check_value("led", '0, led);
        end
    endtask

    initial begin
        data_t         rd;
        addr_t         adr;
        strb_t         sel;
        data_t         dat;
        int            lat;
        int            elapsed;
        int            i;
        logic [GW-1:0] sw_new;
        errors    = 0;
        checks    = 0;
        seed      = 97;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_sel    = '0;
        wb_dat_w  = '0;
        sw        = '0;
        led_model = '0;
        // outputs clear from the first reset edge on
        @(posedge clk);
        watch_reset(3);
        #1;
        rst = 1'b0;

        // led write held across the reset stretch
        fork
            begin
                wb_access(1'b1, 16'h8000, 4'b0011, 32'h0000_5a3c, rd, lat);
                checks++;
                assert (lat >= 18) else begin
                    $display("error at time %0t: wb_ack latency expected at least 18, got %0d",
                             $time, lat);
                    errors++;
                end
            end
            watch_reset(17);
        join
        led_model = 16'h5a3c;
        check_value("led", led_model, led);

        // random traffic over both memories, aliasing included
        for (i = 0; i < 200; i++) begin
            adr      = addr_t'($random(seed));
            adr[15]  = 1'b0;
            adr[1:0] = 2'b00;
            sel      = strb_t'($random(seed));
            if (sel == '0) begin
                sel = 4'hf;
            end
            dat = $random(seed);
            mem_write(adr, sel, dat);
            written.push_back(adr);
        end
        for (i = 0; i < written.size(); i++) begin
            mem_read_check(written[i]);
        end

        // same offset in both regions
        mem_write(16'h0100, 4'hf, 32'h1111_1111);
        mem_write(16'h4100, 4'hf, 32'h2222_2222);
        mem_read_check(16'h0100);
        mem_read_check(16'h4100);

        // low byte write, then toggle
        reg_access(1'b1, 16'h8000, 4'b0001, 32'hffff_ffc3, rd);
        led_model[7:0] = 8'hc3;
        check_value("led", led_model, led);
        reg_access(1'b1, 16'h8008, 4'hf, 32'h0000_0f0f, rd);
        led_model = led_model ^ 16'h0f0f;
        check_value("led", led_model, led);
        reg_access(1'b0, 16'h8000, 4'hf, '0, rd);
        check_value("wb_dat_r", {16'h0, led_model}, rd);
        reg_access(1'b0, 16'h8008, 4'hf, '0, rd);
        check_value("wb_dat_r", {16'h0, led_model}, rd);

        // switches show up after the synchronizer
        sw_new  = 16'hbeef;
        sw      = sw_new;
        elapsed = 0;
        rd      = '0;
        while (rd !== {16'h0, sw_new} && elapsed + 3 <= 10) begin
            reg_access(1'b0, 16'h8004, 4'hf, '0, rd);
            elapsed += 3;
        end
        check_value("wb_dat_r", {16'h0, sw_new}, rd);

        // unmapped space reads zero and swallows writes
        reg_access(1'b0, 16'hc000, 4'hf, '0, rd);
        check_value("wb_dat_r", '0, rd);
        reg_access(1'b1, 16'hc100, 4'hf, 32'hffff_ffff, rd);
        check_value("led", led_model, led);
        mem_read_check(16'h0100);
        mem_read_check(16'h4100);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: soc_board.f
+incdir+.
soc_pkg.sv
rst_stretch.sv
wb_decoder.sv
wb_to_mem.sv
sp_mem.sv
gpio_regs.sv
soc_board.sv
tb_soc_board.sv
